/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing -Wno-fatal
TOP     = tb_mmu_top
FLIST   = flist.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
PASS    = ALL TESTS PASSED
SRCS    = $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+include
rtl/mips_addr_pkg.sv
rtl/tlb_pkg.sv
rtl/mmu_addr_map.sv
rtl/tlb.sv
rtl/credit_counter.sv
rtl/bus_access_fsm.sv
rtl/mmu_top.sv
test/tb_mem_model.sv
test/tb_mmu_top.sv

/* include/mmu_bus.svh */
// one enable per byte lane of a 32-bit data bus, and all enables low marks a read
`ifndef mmu_bus_svh
`define mmu_bus_svh

`define mmu_ben_w 4             // byte lanes per word
`define mmu_no_write 4'b0000    // no lane written, so a read

`endif

/* rtl/bus_access_fsm.sv */
// one access at a time, the CPU must hold en, wen, wdata and the mapping while stall is high
`default_nettype none
`timescale 1ns/1ps
`include "mmu_bus.svh"

module bus_access_fsm
    import mips_addr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic                  map_valid,
    input  logic [addr_w-1:0]     map_paddr,
    input  logic                  map_cached,
    input  logic                  exc_any,
    input  logic [`mmu_ben_w-1:0] wen,
    input  logic [addr_w-1:0]     wdata,
    input  logic                  avail,
    input  logic                  bus_rvalid,
    input  logic [addr_w-1:0]     bus_rdata,
    output logic                  take,
    output logic                  bus_req,
    output logic [`mmu_ben_w-1:0] bus_wen,
    output logic [addr_w-1:0]     bus_paddr,
    output logic [addr_w-1:0]     bus_wdata,
    output logic                  bus_cached,
    output logic [addr_w-1:0]     rdata,
    output logic                  stall
);

    logic [1:0]        state;
    logic [addr_w-1:0] rdata_q;
    logic              accept;
    logic              is_read;
    logic              rd_done;

    assign accept  = en && map_valid && !exc_any;
    assign is_read = bus_wen == `mmu_no_write;
    assign rd_done = (state == st_wait_read) && bus_rvalid;
    assign take    = bus_req;    // one credit per request cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            bus_req <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state   <= st_issue;
                        bus_req <= avail;    // no credit yet, retry in issue
                    end
                end
                st_issue: begin
                    if (bus_req) begin
                        bus_req <= 1'b0;
                        state   <= is_read ? st_wait_read : st_done;
                    end else begin
                        bus_req <= avail;
                    end
                end
                st_wait_read: begin
                    if (bus_rvalid) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;    // done, old access still on the inputs
            endcase
        end
    end

    // request payload captured once per access
    always_ff @(posedge clk) begin
        if (state == st_idle && accept) begin
            bus_wen    <= wen;
            bus_paddr  <= map_paddr;
            bus_wdata  <= wdata;
            bus_cached <= map_cached;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_done) begin
            rdata_q <= bus_rdata;
        end
    end

    assign rdata = rd_done ? bus_rdata : rdata_q;

    always_comb begin
        case (state)
            st_idle:      stall = en && !exc_any;    // exceptions finish at once
            st_issue:     stall = 1'b1;
            st_wait_read: stall = !bus_rvalid;
            st_done:      stall = 1'b0;
            default:      stall = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/credit_counter.sv */
// take must only be high while avail is high, and returns never exceed the credits granted at reset
`default_nettype none
`timescale 1ns/1ps

module credit_counter
    import mips_addr_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic take,
    input  logic give,
    output logic avail
);

    logic [credit_w-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= credit_w'(mem_credits);
        end else begin
            case ({take, give})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;    // both or neither cancel out
            endcase
        end
    end

    assign avail = count != '0;

endmodule

`default_nettype wire

/* rtl/mips_addr_pkg.sv */
// MIPS32 address map with 512 MB kernel segments, Config0 K0 at bits 2:0, and credits sized for one memory
`default_nettype none

package mips_addr_pkg;

    localparam int unsigned addr_w = 32;    // address and data width

    // segment code sits in vaddr[31:29]
    localparam int unsigned seg_lsb = 29;
    localparam logic [2:0] seg_kseg0 = 3'b100;    // unmapped, cacheability from config
    localparam logic [2:0] seg_kseg1 = 3'b101;    // unmapped, never cached
    localparam logic [2:0] seg_kseg2 = 3'b110;    // kernel mapped
    localparam logic [2:0] seg_kseg3 = 3'b111;    // kernel mapped
    // any other code is kuseg

    // cp0 bit positions
    localparam int unsigned erl_bit = 2;    // status.erl
    localparam int unsigned k0_lsb = 0;     // config.k0, 3-bit field
    localparam logic [2:0] cca_cached = 3'd3;    // cacheable noncoherent

    // memory bus flow control
    localparam int unsigned mem_credits = 4;    // granted at reset
    localparam int unsigned credit_w = $clog2(mem_credits + 1);

    // bus access FSM encoding
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_issue = 2'd1;    // waiting for a credit or sending
    localparam logic [1:0] st_wait_read = 2'd2;
    localparam logic [1:0] st_done = 2'd3;     // posted write completes here

endpackage

`default_nettype wire

/* rtl/mmu_addr_map.sv */
// combinational, with exceptions and mapped results valid only while tlb_rdy is high and inputs held
`default_nettype none
`timescale 1ns/1ps
`include "mmu_bus.svh"

module mmu_addr_map
    import mips_addr_pkg::*;
(
    input  logic                  en,
    input  logic [`mmu_ben_w-1:0] wen,
    input  logic [addr_w-1:0]     vaddr,
    input  logic [addr_w-1:0]     cp0_status,
    input  logic [addr_w-1:0]     cp0_config,
    input  logic                  tlb_rdy,
    input  logic [addr_w-1:0]     tlb_paddr,
    input  logic                  tlb_cached,
    input  logic                  tlb_miss,
    input  logic                  tlb_invalid,
    input  logic                  tlb_nodirty,
    output logic                  tlb_en,
    output logic [addr_w-1:0]     tlb_vaddr,
    output logic                  tlb_store,
    output logic                  map_valid,
    output logic [addr_w-1:0]     map_paddr,
    output logic                  map_cached,
    output logic                  exc_tlbr,
    output logic                  exc_tlbi,
    output logic                  exc_tlbm
);

    logic [2:0]        seg;
    logic              seg_mapped;
    logic              use_tlb;
    logic              tlb_fault;
    logic [addr_w-1:0] direct_paddr;

    assign seg          = vaddr[addr_w-1:seg_lsb];
    assign direct_paddr = {3'b000, vaddr[seg_lsb-1:0]};    // strip segment bits
    assign use_tlb      = seg_mapped && !cp0_status[erl_bit];    // erl bypasses the tlb
    assign tlb_fault    = tlb_miss || tlb_invalid || tlb_nodirty;

    always_comb begin
        case (seg)
            seg_kseg0, seg_kseg1: seg_mapped = 1'b0;
            seg_kseg2, seg_kseg3: seg_mapped = 1'b1;    // kernel mapped
            default:              seg_mapped = 1'b1;    // kuseg
        endcase
    end

    // lookup request, held as long as the cpu holds the access
    assign tlb_en    = en && use_tlb;
    assign tlb_vaddr = vaddr;
    assign tlb_store = wen != `mmu_no_write;

    always_comb begin
        map_valid  = 1'b0;
        map_paddr  = direct_paddr;
        map_cached = 1'b0;
        exc_tlbr   = 1'b0;
        exc_tlbi   = 1'b0;
        exc_tlbm   = 1'b0;
        if (en) begin
            if (use_tlb) begin
                map_paddr  = tlb_paddr;
                map_cached = tlb_cached;
                map_valid  = tlb_rdy && !tlb_fault;
                exc_tlbr   = tlb_rdy && tlb_miss;
                exc_tlbi   = tlb_rdy && tlb_invalid;
                exc_tlbm   = tlb_rdy && tlb_nodirty;
            end else begin
                map_valid = 1'b1;
                // kseg1 and erl accesses stay uncached
                map_cached = (seg == seg_kseg0)
                             && (cp0_config[k0_lsb +: 3] == cca_cached);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mmu_top.sv */
// exceptions complete without touching the bus, and only one access is tracked at a time
`default_nettype none
`timescale 1ns/1ps
`include "mmu_bus.svh"

module mmu_top
    import mips_addr_pkg::*, tlb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [`mmu_ben_w-1:0] wen,
    input  logic [addr_w-1:0]     vaddr,
    input  logic [addr_w-1:0]     wdata,
    output logic [addr_w-1:0]     rdata,
    output logic                  stall,
    output logic                  exc_tlbr,
    output logic                  exc_tlbi,
    output logic                  exc_tlbm,
    input  logic [addr_w-1:0]     cp0_status,
    input  logic [addr_w-1:0]     cp0_config,
    input  logic                  tlb_we,
    input  logic [tlb_idx_w-1:0]  tlb_index,
    input  logic                  tlb_wsel,
    input  tlb_word_u             tlb_wdata,
    output logic                  bus_req,
    output logic                  bus_wen_dummy_unused_never,
    output logic [`mmu_ben_w-1:0] bus_wen,
    output logic [addr_w-1:0]     bus_paddr,
    output logic [addr_w-1:0]     bus_wdata,
    output logic                  bus_cached,
    input  logic                  bus_credit,
    input  logic                  bus_rvalid,
    input  logic [addr_w-1:0]     bus_rdata
);

    logic              tlb_en;
    logic [addr_w-1:0] tlb_vaddr;
    logic              tlb_store;
    logic              tlb_rdy;
    logic [addr_w-1:0] tlb_paddr;
    logic              tlb_cached;
    logic              tlb_miss;
    logic              tlb_invalid;
    logic              tlb_nodirty;
    logic              map_valid;
    logic [addr_w-1:0] map_paddr;
    logic              map_cached;
    logic              exc_any;
    logic              avail;
    logic              take;

    assign exc_any = exc_tlbr || exc_tlbi || exc_tlbm;
    assign bus_wen_dummy_unused_never = 1'b0;

    mmu_addr_map u_addr_map (
        .en(en), .wen(wen), .vaddr(vaddr),
        .cp0_status(cp0_status), .cp0_config(cp0_config),
        .tlb_rdy(tlb_rdy), .tlb_paddr(tlb_paddr), .tlb_cached(tlb_cached),
        .tlb_miss(tlb_miss), .tlb_invalid(tlb_invalid), .tlb_nodirty(tlb_nodirty),
        .tlb_en(tlb_en), .tlb_vaddr(tlb_vaddr), .tlb_store(tlb_store),
        .map_valid(map_valid), .map_paddr(map_paddr), .map_cached(map_cached),
        .exc_tlbr(exc_tlbr), .exc_tlbi(exc_tlbi), .exc_tlbm(exc_tlbm)
    );

    tlb u_tlb (
        .clk(clk), .rst_n(rst_n),
        .lookup_en(tlb_en), .lookup_vaddr(tlb_vaddr), .lookup_store(tlb_store),
        .tlb_we(tlb_we), .tlb_index(tlb_index), .tlb_wsel(tlb_wsel), .tlb_wdata(tlb_wdata),
        .rdy(tlb_rdy), .paddr(tlb_paddr), .cached(tlb_cached),
        .miss(tlb_miss), .invalid(tlb_invalid), .nodirty(tlb_nodirty)
    );

    credit_counter u_credits (
        .clk(clk), .rst_n(rst_n), .take(take), .give(bus_credit), .avail(avail)
    );

    bus_access_fsm u_bus_fsm (
        .clk(clk), .rst_n(rst_n), .en(en),
        .map_valid(map_valid), .map_paddr(map_paddr), .map_cached(map_cached),
        .exc_any(exc_any), .wen(wen), .wdata(wdata), .avail(avail),
        .bus_rvalid(bus_rvalid), .bus_rdata(bus_rdata),
        .take(take), .bus_req(bus_req), .bus_wen(bus_wen), .bus_paddr(bus_paddr),
        .bus_wdata(bus_wdata), .bus_cached(bus_cached), .rdata(rdata), .stall(stall)
    );

endmodule

`default_nettype wire

/* rtl/tlb.sv */
// eight fully associative 4 KB entries, lowest index wins on a multiple match, result lags vaddr by one cycle
`default_nettype none
`timescale 1ns/1ps

module tlb
    import mips_addr_pkg::*, tlb_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lookup_en,
    input  logic [addr_w-1:0]    lookup_vaddr,
    input  logic                 lookup_store,
    input  logic                 tlb_we,
    input  logic [tlb_idx_w-1:0] tlb_index,
    input  logic                 tlb_wsel,
    input  tlb_word_u            tlb_wdata,
    output logic                 rdy,
    output logic [addr_w-1:0]    paddr,
    output logic                 cached,
    output logic                 miss,
    output logic                 invalid,
    output logic                 nodirty
);

    tlb_entryhi_t ehi [tlb_entries];
    tlb_entrylo_t elo [tlb_entries];

    logic [tlb_entries-1:0] hit_vec;
    logic                   hit_any;
    tlb_entrylo_t           hit_lo;

    logic                   res_valid;
    logic [addr_w-1:0]      res_vaddr;
    logic                   res_hit;
    tlb_entrylo_t           res_lo;

    // all entries start invalid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < tlb_entries; i++) begin
                ehi[i] <= '0;
                elo[i] <= '0;
            end
        end else if (tlb_we) begin
            if (tlb_wsel) begin
                elo[tlb_index] <= tlb_wdata.lo;
            end else begin
                ehi[tlb_index] <= tlb_wdata.hi;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            hit_vec[i] = ehi[i].vpn == lookup_vaddr[addr_w-1 -: vpn_w];
        end
    end

    always_comb begin
        hit_lo = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_lo = elo[i];    // lower index overrides
            end
        end
    end

    assign hit_any = |hit_vec;

    // a write invalidates the held result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= lookup_en && !tlb_we;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            res_vaddr <= lookup_vaddr;
            res_hit   <= hit_any;
            res_lo    <= hit_lo;
        end
    end

    assign rdy     = res_valid && lookup_en && (res_vaddr == lookup_vaddr);
    assign paddr   = {res_lo.pfn, res_vaddr[page_w-1:0]};
    assign cached  = res_lo.c;
    assign miss    = !res_hit;
    assign invalid = res_hit && !res_lo.v;
    assign nodirty = res_hit && res_lo.v && !res_lo.d && lookup_store;    // store to clean page

endmodule

`default_nettype wire

/* rtl/tlb_pkg.sv */
// one 4 KB page per entry with no ASID, no global bit and no even/odd pair
`default_nettype none

package tlb_pkg;

    localparam int unsigned tlb_entries = 8;
    localparam int unsigned tlb_idx_w = $clog2(tlb_entries);

    localparam int unsigned page_w = 12;    // page offset bits
    localparam int unsigned vpn_w = 20;     // also the pfn width

    // EntryHi as written by software
    typedef struct packed {
        logic [vpn_w-1:0]  vpn;
        logic [page_w-1:0] rsvd;    // asid field not implemented
    } tlb_entryhi_t;

    // EntryLo, single page
    typedef struct packed {
        logic [vpn_w-1:0] pfn;
        logic [7:0]       rsvd_hi;
        logic             c;        // cached
        logic             d;        // dirty, writes allowed
        logic             v;        // valid
        logic             rsvd_lo;  // global bit not implemented
    } tlb_entrylo_t;

    // the same write word, read as EntryHi or EntryLo
    typedef union packed {
        tlb_entryhi_t hi;
        tlb_entrylo_t lo;
    } tlb_word_u;

endpackage

`default_nettype wire

/* test/tb_mem_model.sv */
// one read outstanding at a time, credits come back at most one per cycle, unwritten bytes read a fill pattern
`default_nettype none
`timescale 1ns/1ps
`include "mmu_bus.svh"

module tb_mem_model
    import mips_addr_pkg::*;
#(
    parameter logic [31:0] seed = 32'd48697
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bus_req,
    input  logic [`mmu_ben_w-1:0] bus_wen,
    input  logic [addr_w-1:0]     bus_paddr,
    input  logic [addr_w-1:0]     bus_wdata,
    output logic                  bus_credit,
    output logic                  bus_rvalid,
    output logic [addr_w-1:0]     bus_rdata,
    output logic                  overdrawn
);

    logic [7:0]  mem [logic [addr_w-1:0]];
    logic [31:0] rng = seed;

    function automatic logic [15:0] step_random();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng[30:15];
    endfunction

    function automatic logic [7:0] fill_byte(input logic [addr_w-1:0] a);
        return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    // request seen in a cycle, credit and read data answered in that cycle or later
    initial begin
        logic [15:0]       r;
        logic [addr_w-1:0] a;
        logic [addr_w-1:0] read_word;
        logic              read_busy;
        int unsigned       read_due;
        int unsigned       now;
        int unsigned       due;
        int unsigned       last_credit;
        int unsigned       free_credits;
        int unsigned       credit_due [$];
        bus_credit = 1'b0;
        bus_rvalid = 1'b0;
        bus_rdata  = '0;
        overdrawn  = 1'b0;
        read_busy  = 1'b0;
        forever begin
            @(negedge clk);
            bus_credit = 1'b0;
            bus_rvalid = 1'b0;
            if (!rst_n) begin
                now          = 0;
                last_credit  = 0;
                free_credits = mem_credits;
                read_busy    = 1'b0;
                credit_due.delete();
            end else begin
                now++;
                if (bus_req) begin
                    if (free_credits == 0) begin
                        overdrawn = 1'b1;    // request with no credit left
                    end else begin
                        free_credits--;
                    end
                    r   = step_random();
                    due = now + r % 6 + ((r[15:13] == 3'd0) ? 16 : 0);    // rare long hold
                    if (due <= last_credit) begin
                        due = last_credit + 1;
                    end
                    credit_due.push_back(due);
                    last_credit = due;
                    if (bus_wen == `mmu_no_write) begin
                        for (int k = 0; k < 4; k++) begin
                            a = {bus_paddr[31:2], 2'(k)};
                            read_word[8*k +: 8] = mem.exists(a) ? mem[a] : fill_byte(a);
                        end
                        read_due  = now + 1 + step_random() % 6;
                        read_busy = 1'b1;
                    end else begin
                        for (int k = 0; k < 4; k++) begin
                            if (bus_wen[k]) begin
                                mem[{bus_paddr[31:2], 2'(k)}] = bus_wdata[8*k +: 8];
                            end
                        end
                    end
                end
                if (credit_due.size() != 0 && credit_due[0] == now) begin
                    void'(credit_due.pop_front());
                    bus_credit = 1'b1;
                    free_credits++;
                end
                if (read_busy && read_due == now) begin
                    bus_rvalid = 1'b1;
                    bus_rdata  = read_word;
                    read_busy  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_mmu_top.sv */
// one access at a time, TLB entries have distinct VPNs, traffic stays in a 32 KB physical window
`default_nettype none
`timescale 1ns/1ps
`include "mmu_bus.svh"

module tb_mmu_top
    import mips_addr_pkg::*, tlb_pkg::*;
();

    localparam int unsigned n_access     = 2000;
    localparam int unsigned max_cycles   = n_access * 20;    // worst case per access
    localparam int unsigned reset_cycles = 4;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  en;
    logic [`mmu_ben_w-1:0] wen;
    logic [addr_w-1:0]     vaddr;
    logic [addr_w-1:0]     wdata;
    logic [addr_w-1:0]     rdata;
    logic                  stall;
    logic                  exc_tlbr;
    logic                  exc_tlbi;
    logic                  exc_tlbm;
    logic [addr_w-1:0]     cp0_status;
    logic [addr_w-1:0]     cp0_config;
    logic                  tlb_we;
    logic [tlb_idx_w-1:0]  tlb_index;
    logic                  tlb_wsel;
    logic [addr_w-1:0]     tlb_wdata;
    logic                  bus_req;
    logic                  bus_wen_dummy_unused_never;
    logic [`mmu_ben_w-1:0] bus_wen;
    logic [addr_w-1:0]     bus_paddr;
    logic [addr_w-1:0]     bus_wdata;
    logic                  bus_cached;
    logic                  bus_credit;
    logic                  bus_rvalid;
    logic [addr_w-1:0]     bus_rdata;
    logic                  overdrawn;

    logic [vpn_w-1:0] ent_vpn [tlb_entries];
    logic [vpn_w-1:0] ent_pfn [tlb_entries];
    logic             ent_c [tlb_entries];
    logic             ent_d [tlb_entries];
    logic             ent_v [tlb_entries];
    logic [7:0]       ref_mem [logic [addr_w-1:0]];
    logic [31:0]      rng = 32'd48697;
    int unsigned      cycles = 0;

    always #2 clk = ~clk;

    mmu_top mmu_top_inst (
        .clk(clk), .rst_n(rst_n), .en(en), .wen(wen), .vaddr(vaddr), .wdata(wdata),
        .rdata(rdata), .stall(stall),
        .exc_tlbr(exc_tlbr), .exc_tlbi(exc_tlbi), .exc_tlbm(exc_tlbm),
        .cp0_status(cp0_status), .cp0_config(cp0_config),
        .tlb_we(tlb_we), .tlb_index(tlb_index), .tlb_wsel(tlb_wsel), .tlb_wdata(tlb_wdata),
        .bus_req(bus_req),
        .bus_wen_dummy_unused_never(bus_wen_dummy_unused_never),
        .bus_wen(bus_wen),
        .bus_paddr(bus_paddr), .bus_wdata(bus_wdata), .bus_cached(bus_cached),
        .bus_credit(bus_credit), .bus_rvalid(bus_rvalid), .bus_rdata(bus_rdata)
    );

    tb_mem_model #(.seed(32'd48697)) mem_model (
        .clk(clk), .rst_n(rst_n), .bus_req(bus_req), .bus_wen(bus_wen),
        .bus_paddr(bus_paddr), .bus_wdata(bus_wdata), .bus_credit(bus_credit),
        .bus_rvalid(bus_rvalid), .bus_rdata(bus_rdata), .overdrawn(overdrawn)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout, the accesses did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [15:0] next_random();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng[30:15];
    endfunction

    function automatic logic [7:0] fill_byte(input logic [addr_w-1:0] a);
        return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        en = 1'b0;
        #1;
        check("bus_req", bus_req, 1'b0);
        check("stall", stall, 1'b0);
    endtask

    task automatic load_tlb_entry(input int i);
        logic [15:0] r;
        logic [2:0]  top;
        r   = next_random();
        top = r[2:0];
        if (top[2:1] == 2'b10) begin
            top[2] = 1'b0;    // keep the page in a mapped segment
        end
        ent_vpn[i] = {top, 14'd0, 3'(i)};
        ent_pfn[i] = {17'd0, r[5:3]};
        ent_v[i]   = r[7:6] != 2'd0;
        ent_d[i]   = r[8];
        ent_c[i]   = r[9];
        @(negedge clk);
        tlb_we    = 1'b1;
        tlb_index = tlb_idx_w'(i);
        tlb_wsel  = 1'b0;    // EntryHi half
        tlb_wdata = {ent_vpn[i], 12'd0};
        @(negedge clk);
        tlb_wsel  = 1'b1;
        tlb_wdata = {ent_pfn[i], 8'd0, ent_c[i], ent_d[i], ent_v[i], 1'b0};
        @(negedge clk);
        tlb_we = 1'b0;
    endtask

    task automatic run_access();
        logic [15:0]       r;
        logic [15:0]       r2;
        logic [2:0]        seg;
        logic [2:0]        pick;
        logic [2:0]        k0;
        logic [2:0]        exp_exc;    // tlbr, tlbi, tlbm
        logic              erl;
        logic              store;
        logic              exp_cached;
        logic              finished;
        logic [addr_w-1:0] va;
        logic [addr_w-1:0] exp_paddr;
        logic [addr_w-1:0] exp_rdata;
        logic [addr_w-1:0] a;
        int                hit;
        int                reqs;
        r    = next_random();
        r2   = next_random();
        pick = r[2:0];
        seg  = (r[4:3] == 2'd0) ? seg_kseg0 : (r[4:3] == 2'd1) ? seg_kseg1 : ent_vpn[pick][19:17];
        if (r[4] && r[6:5] == 2'd0) begin
            seg = r2[13:11];    // any mapped segment and often a miss
            if (seg[2:1] == 2'b10) begin
                seg[2] = 1'b0;
            end
        end
        va    = {seg, 14'd0, pick, 6'd0, r2[3:0], 2'b00};
        erl   = r[10:8] == 3'd0;
        k0    = r[11] ? 3'd3 : r2[10:8];
        store = !r[7];
        // reference translation
        exp_exc    = 3'b000;
        exp_paddr  = {3'b000, va[28:0]};
        exp_cached = (seg == seg_kseg0) && (k0 == 3'd3);
        if (seg != seg_kseg0 && seg != seg_kseg1 && !erl) begin
            hit = -1;
            for (int i = 0; i < tlb_entries; i++) begin
                if (hit < 0 && ent_vpn[i] == va[31:12]) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                exp_exc = 3'b100;
            end else begin
                exp_paddr  = {ent_pfn[hit], va[11:0]};
                exp_cached = ent_c[hit];
                if (!ent_v[hit]) begin
                    exp_exc = 3'b010;
                end else if (store && !ent_d[hit]) begin
                    exp_exc = 3'b001;    // store to a clean page
                end
            end
        end
        for (int k = 0; k < 4; k++) begin
            a = {exp_paddr[31:2], 2'(k)};
            exp_rdata[8*k +: 8] = ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
        end
        @(negedge clk);
        en         = 1'b1;
        wen        = !store ? `mmu_no_write : (r2[7:4] == 4'd0) ? 4'hf : r2[7:4];
        vaddr      = va;
        wdata      = {next_random(), next_random()};
        cp0_status = '0;
        cp0_status[erl_bit] = erl;
        cp0_config = '0;
        cp0_config[k0_lsb +: 3] = k0;
        reqs       = 0;
        finished   = 1'b0;
        while (!finished) begin
            #1;
            check("overdrawn", overdrawn, 1'b0);
            check("bus_wen_dummy_unused_never", bus_wen_dummy_unused_never, 1'b0);
            if (bus_req) begin
                reqs++;
                check("bus_paddr", bus_paddr, exp_paddr);
                check("bus_wen", bus_wen, wen);
                check("bus_wdata", bus_wdata, wdata);
                check("bus_cached", bus_cached, exp_cached);
            end
            finished = !stall;
            if (!finished) begin
                @(negedge clk);
            end
        end
        check("exc_tlbr_tlbi_tlbm", {exc_tlbr, exc_tlbi, exc_tlbm}, exp_exc);
        check("bus_req_count", reqs, (exp_exc == 3'b000) ? 1 : 0);
        if (exp_exc == 3'b000 && !store) begin
            check("rdata", rdata, exp_rdata);
        end
        if (exp_exc == 3'b000 && store) begin
            for (int k = 0; k < 4; k++) begin
                if (wen[k]) begin
                    ref_mem[{exp_paddr[31:2], 2'(k)}] = wdata[8*k +: 8];
                end
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        en         = 1'b0;
        wen        = '0;
        vaddr      = '0;
        wdata      = '0;
        cp0_status = '0;
        cp0_config = '0;
        tlb_we     = 1'b0;
        tlb_index  = '0;
        tlb_wsel   = 1'b0;
        tlb_wdata  = '0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check("bus_req", bus_req, 1'b0);
        check("stall", stall, 1'b0);
        check("exc_tlbr_tlbi_tlbm", {exc_tlbr, exc_tlbi, exc_tlbm}, 3'b000);
        for (int n = 0; n < n_access; n++) begin
            if (n % 500 == 0) begin
                idle_cycle();    // fresh TLB contents now and then
                for (int i = 0; i < tlb_entries; i++) begin
                    load_tlb_entry(i);
                end
            end
            run_access();
            if (next_random() % 4 == 0) begin
                idle_cycle();
            end
        end
        idle_cycle();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
